//--- Bender.yml
package:
  name: lcd_spi

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lcd_pkg.sv
      - rtl/lcd_cmd_fifo.sv
      - rtl/lcd_sck_gen.sv
      - rtl/lcd_spi_tx.sv
      - rtl/lcd_wb_regs.sv
      - rtl/lcd_spi_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/lcd_spi_assert.sv
      - tests/lcd_spi_tb.sv

//--- rtl/lcd_cmd_fifo.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcd_cmd_fifo (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                push_i,
  input  lcd_pkg::lcd_entry_t push_entry_i,
  input  logic                pop_i,
  output lcd_pkg::lcd_entry_t head_o,
  output logic                empty_o,
  output logic                full_o
);
  import lcd_pkg::*;

  localparam int AW = $clog2(`LCD_FIFO_DEPTH);

  lcd_entry_t  mem [`LCD_FIFO_DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        do_push;
  logic        do_pop;

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr[AW-1:0]] <= push_entry_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      wr_ptr <= wr_ptr + (AW+1)'(do_push);
      rd_ptr <= rd_ptr + (AW+1)'(do_pop);
    end
  end

  // the extra pointer bit flips on every wrap, so equal addresses with
  // different wrap bits mean the buffer is full
  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign head_o  = mem[rd_ptr[AW-1:0]];

endmodule

//--- rtl/lcd_pkg.sv
package lcd_pkg;

  typedef logic [31:0] wb_adr_t;
  typedef logic [31:0] wb_dat_t;
  typedef logic [15:0] lcd_word_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // wishbone request and response
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat;
  } bus_req_t;

  typedef struct packed {
    logic    ack;
    wb_dat_t dat;
  } bus_rsp_t;

  // one queued panel word, is_cmd selects the level of the dc line
  typedef struct packed {
    logic      is_cmd;
    lcd_word_t word;
  } lcd_entry_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_REQ,
    TX_SHIFT,
    TX_END
  } tx_state_t;

endpackage

//--- rtl/lcd_sck_gen.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcd_sck_gen (
  input  logic clk,
  input  logic arst_n_i,
  output logic sck_o,
  output logic rise_o,
  output logic fall_o
);

  localparam int CW = $clog2(`LCD_SCK_HALF + 1);

  logic [CW-1:0] cnt;
  logic          toggle;

  assign toggle = (cnt == CW'(`LCD_SCK_HALF - 1));

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cnt   <= '0;
      sck_o <= 1'b0;
    end
    else if (toggle)
    begin
      cnt   <= '0;
      sck_o <= ~sck_o;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

  // strobes sit in the cycle whose closing edge flips the level
  assign rise_o = toggle & ~sck_o;
  assign fall_o = toggle & sck_o;

endmodule

//--- rtl/lcd_settings.svh
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command queue and serial timing

// must stay a power of two
`define LCD_FIFO_DEPTH 4

// serial clock half period in clk cycles
`define LCD_SCK_HALF 2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map, word index taken from address bits 31:2
`define LCD_REG_STATUS 0
`define LCD_REG_CMD    1
`define LCD_REG_DATA   2

`endif

//--- rtl/lcd_spi_top.sv
`timescale 1ns/10ps

module lcd_spi_top (
  input  logic              clk,
  input  logic              arst_n_i,
  input  lcd_pkg::bus_req_t bus_i,
  output lcd_pkg::bus_rsp_t bus_o,
  output logic              spi_req_o,
  input  logic              spi_ack_i,
  output logic              spi_done_o,
  output logic              cs_o,
  output logic              dc_o,
  output logic              sck_o,
  output logic              sdo_o
);
  import lcd_pkg::*;

  lcd_entry_t push_entry;
  lcd_entry_t head;
  logic       push;
  logic       fifo_full;
  logic       fifo_empty;
  logic       busy;
  logic       sck_lvl;
  logic       sck_rise;
  logic       sck_fall;

  lcd_wb_regs regs (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .bus_i        (bus_i),
    .bus_o        (bus_o),
    .fifo_full_i  (fifo_full),
    .busy_i       (busy),
    .push_o       (push),
    .push_entry_o (push_entry)
  );

  // the done strobe of the transmitter pops the head entry
  lcd_cmd_fifo fifo (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .push_i       (push),
    .push_entry_i (push_entry),
    .pop_i        (spi_done_o),
    .head_o       (head),
    .empty_o      (fifo_empty),
    .full_o       (fifo_full)
  );

  lcd_sck_gen sck (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .sck_o    (sck_lvl),
    .rise_o   (sck_rise),
    .fall_o   (sck_fall)
  );

  lcd_spi_tx tx (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .sck_i      (sck_lvl),
    .rise_i     (sck_rise),
    .fall_i     (sck_fall),
    .empty_i    (fifo_empty),
    .head_i     (head),
    .spi_req_o  (spi_req_o),
    .spi_ack_i  (spi_ack_i),
    .spi_done_o (spi_done_o),
    .busy_o     (busy),
    .cs_o       (cs_o),
    .dc_o       (dc_o),
    .sck_o      (sck_o),
    .sdo_o      (sdo_o)
  );

endmodule

//--- rtl/lcd_spi_tx.sv
`timescale 1ns/10ps

module lcd_spi_tx (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                sck_i,
  input  logic                rise_i,
  input  logic                fall_i,
  input  logic                empty_i,
  input  lcd_pkg::lcd_entry_t head_i,
  output logic                spi_req_o,
  input  logic                spi_ack_i,
  output logic                spi_done_o,
  output logic                busy_o,
  output logic                cs_o,
  output logic                dc_o,
  output logic                sck_o,
  output logic                sdo_o
);
  import lcd_pkg::*;

  tx_state_t state;
  lcd_word_t shreg;
  logic [4:0] bit_cnt;
  logic       load;
  logic       shift;
  logic       last;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // every bit event is aligned to the falling edge strobe
  assign load  = (state == TX_REQ) & spi_ack_i & fall_i;
  assign shift = (state == TX_SHIFT) & fall_i & (bit_cnt != 5'd16);
  assign last  = (state == TX_SHIFT) & fall_i & (bit_cnt == 5'd16);

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      shreg <= head_i.word;
    end
    else if (shift)
    begin
      shreg <= {shreg[14:0], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state      <= TX_IDLE;
      spi_req_o  <= 1'b0;
      spi_done_o <= 1'b0;
      cs_o       <= 1'b1;
      dc_o       <= 1'b0;
      sdo_o      <= 1'b0;
      bit_cnt    <= '0;
    end
    else
    begin
      case (state)
        TX_IDLE:
        begin
          if (!empty_i)
          begin
            state     <= TX_REQ;
            spi_req_o <= 1'b1;
          end
        end
        TX_REQ:
        begin
          if (load)
          begin
            state   <= TX_SHIFT;
            cs_o    <= 1'b0;
            dc_o    <= ~head_i.is_cmd;
            sdo_o   <= head_i.word[15];
            bit_cnt <= '0;
          end
        end
        TX_SHIFT:
        begin
          if (rise_i)
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
          if (shift)
          begin
            sdo_o <= shreg[14];
          end
          // done doubles as the FIFO pop and falls again in TX_END
          if (last)
          begin
            state      <= TX_END;
            cs_o       <= 1'b1;
            sdo_o      <= 1'b0;
            spi_done_o <= 1'b1;
            spi_req_o  <= 1'b0;
          end
        end
        default:
        begin
          state      <= TX_IDLE;
          spi_done_o <= 1'b0;
        end
      endcase
    end
  end

  assign sck_o  = sck_i & ~cs_o;
  assign busy_o = (state != TX_IDLE) | ~empty_i;

endmodule

//--- rtl/lcd_wb_regs.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcd_wb_regs (
  input  logic                clk,
  input  logic                arst_n_i,
  input  lcd_pkg::bus_req_t   bus_i,
  output lcd_pkg::bus_rsp_t   bus_o,
  input  logic                fifo_full_i,
  input  logic                busy_i,
  output logic                push_o,
  output lcd_pkg::lcd_entry_t push_entry_o
);
  import lcd_pkg::*;

  logic [29:0] word_idx;
  logic        req_ok;
  logic        hit_fifo;
  logic        stall;
  logic        ack_q;
  wb_dat_t     rdat_q;

  assign word_idx = bus_i.adr[31:2];

  // a request already acked this cycle is not taken a second time
  assign req_ok   = bus_i.cyc & bus_i.stb & ~ack_q;
  assign hit_fifo = (word_idx == `LCD_REG_CMD) | (word_idx == `LCD_REG_DATA);
  assign stall    = bus_i.we & hit_fifo & fifo_full_i;
  assign push_o   = req_ok & bus_i.we & hit_fifo & ~fifo_full_i;

  always_comb
  begin
    push_entry_o.is_cmd = (word_idx == `LCD_REG_CMD);
    push_entry_o.word   = bus_i.dat[15:0];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response path, a stalled write keeps ack low until the FIFO has room
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= req_ok & ~stall;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_ok & ~bus_i.we & (word_idx == `LCD_REG_STATUS))
    begin
      rdat_q <= wb_dat_t'({busy_i, fifo_full_i});
    end
    else
    begin
      rdat_q <= '0;
    end
  end

  assign bus_o.ack = ack_q;
  assign bus_o.dat = rdat_q;

endmodule

//--- sim.f
+incdir+rtl
rtl/lcd_pkg.sv
rtl/lcd_cmd_fifo.sv
rtl/lcd_sck_gen.sv
rtl/lcd_spi_tx.sv
rtl/lcd_wb_regs.sv
rtl/lcd_spi_top.sv
tests/lcd_spi_assert.sv
tests/lcd_spi_tb.sv

//--- tests/lcd_spi_assert.sv
`timescale 1ns/10ps

module lcd_spi_assert (
  input logic               clk,
  input logic               arst_n_i,
  input lcd_pkg::tx_state_t state,
  input logic               spi_ack_i,
  input logic               spi_done_o,
  input logic               rise_i,
  input logic               cs_o,
  input logic               sck_o,
  input logic               sdo_o
);
  import lcd_pkg::*;

  // chip select only drops in the cycle after a sampled grant
  cs_needs_grant: assert property (@(posedge clk) disable iff (!arst_n_i)
    $fell(cs_o) |-> $past(spi_ack_i))
    else $error("cs_o fell without spi_ack_i");

  // the serial clock idles low while chip select is high and is still low
  // in the first cycle after chip select drops
  sck_idle_low: assert property (@(posedge clk) disable iff (!arst_n_i)
    $past(cs_o) |-> !sck_o)
    else $error("sck_o high while cs_o is high or has just fallen");

  done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
    spi_done_o |-> (state == TX_END) ##1 !spi_done_o)
    else $error("spi_done_o longer than one cycle or outside TX_END");

  sdo_stable_on_rise: assert property (@(posedge clk) disable iff (!arst_n_i)
    rise_i |=> $stable(sdo_o))
    else $error("sdo_o changed at a rising sck edge");

endmodule

bind lcd_spi_tx lcd_spi_assert tx_checks (
  .clk        (clk),
  .arst_n_i   (arst_n_i),
  .state      (state),
  .spi_ack_i  (spi_ack_i),
  .spi_done_o (spi_done_o),
  .rise_i     (rise_i),
  .cs_o       (cs_o),
  .sck_o      (sck_o),
  .sdo_o      (sdo_o)
);

//--- tests/lcd_spi_tb.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcd_spi_tb;
  import lcd_pkg::*;

  typedef struct packed {
    logic       hold;
    logic       settle;
    logic [3:0] idx;
    logic       we;
    wb_dat_t    dat;
    wb_dat_t    exp;
  } row_t;

  localparam logic [3:0] ST = 4'(`LCD_REG_STATUS);
  localparam logic [3:0] CM = 4'(`LCD_REG_CMD);
  localparam logic [3:0] DA = 4'(`LCD_REG_DATA);
  localparam int NUM_ROWS = 16;
  localparam int MAX_CYCLES = NUM_ROWS * (16*2*`LCD_SCK_HALF + 4*2*`LCD_SCK_HALF + 8) * 2;

  // hold grant, wait for idle link, register index, write, data, expected read data
  localparam row_t STIM [NUM_ROWS] = '{
    '{1'b0, 1'b1, ST,    1'b0, 32'h0000_0000, 32'h0},
    '{1'b0, 1'b0, CM,    1'b1, 32'h0000_002c, 32'h0},
    '{1'b0, 1'b0, DA,    1'b1, 32'hffff_a5c3, 32'h0},
    '{1'b0, 1'b0, DA,    1'b1, 32'h0000_1234, 32'h0},
    '{1'b0, 1'b0, 4'd5,  1'b1, 32'h0000_dead, 32'h0},
    '{1'b0, 1'b0, 4'd7,  1'b0, 32'h0000_0000, 32'h0},
    '{1'b0, 1'b0, CM,    1'b1, 32'h0000_0036, 32'h0},
    '{1'b0, 1'b1, ST,    1'b0, 32'h0000_0000, 32'h0},
    '{1'b1, 1'b1, DA,    1'b1, 32'h0000_1111, 32'h0},
    '{1'b0, 1'b0, DA,    1'b1, 32'h0000_2222, 32'h0},
    '{1'b0, 1'b0, DA,    1'b1, 32'h0000_3333, 32'h0},
    '{1'b0, 1'b0, DA,    1'b1, 32'h0000_4444, 32'h0},
    '{1'b0, 1'b0, ST,    1'b0, 32'h0000_0000, 32'h3},
    '{1'b0, 1'b0, DA,    1'b1, 32'h0000_5555, 32'h0},
    '{1'b0, 1'b0, CM,    1'b1, 32'h0000_0029, 32'h0},
    '{1'b0, 1'b1, ST,    1'b0, 32'h0000_0000, 32'h0}
  };

  logic       clk = 1'b0;
  logic       arst_n_i;
  bus_req_t   bus_i;
  bus_rsp_t   bus_o;
  logic       spi_req_o, spi_ack_i, spi_done_o;
  logic       cs_o, dc_o, sck_o, sdo_o;
  logic       grant_hold = 1'b0;
  logic       stall_seen = 1'b0;
  logic       sck_prev = 1'b0;
  logic       cs_prev = 1'b1;
  logic [31:0] lcg_state = 32'd34;
  lcd_word_t  rx_word;
  lcd_entry_t exp_q [$];
  int         rx_bits, frames_sent, frames_rx, frames_total, done_cnt, cycles;
  int         err_val, err_other;

  lcd_spi_top dut (.*);

  always #10 clk = ~clk;

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:16];
  endfunction

  function automatic bit is_frame(input row_t r);
    return r.we && (r.idx == CM || r.idx == DA);
  endfunction

  task automatic check_level(input string name, input logic got, input logic want);
    assert (got === want)
    else
    begin
      $display("ERR %s exp %h got %h", name, want, got);
      err_val++;
    end
  endtask

  task automatic wait_idle();
    while (frames_rx != frames_sent)
      @(negedge clk);
    repeat (3)
      @(negedge clk);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one wishbone access, cyc and stb stay up until ack
  task automatic wb_access(input row_t r, output wb_dat_t rdat);
    int wait_cyc;
    wait_cyc = 0;
    bus_i = '{cyc: 1'b1, stb: 1'b1, we: r.we, adr: {26'd0, r.idx, 2'b00}, dat: r.dat};
    @(negedge clk);
    while (!bus_o.ack)
    begin
      wait_cyc++;
      // a write stalled on a full FIFO frees the grant so the queue drains
      if (wait_cyc == 6 && grant_hold)
      begin
        grant_hold = 1'b0;
        stall_seen = 1'b1;
      end
      @(negedge clk);
    end
    rdat = bus_o.dat;
    bus_i = '0;
  endtask

  task automatic check_frame();
    lcd_entry_t want;
    frames_rx++;
    assert (exp_q.size() > 0)
    else
    begin
      $display("a frame arrived with no write left to match it");
      err_other++;
    end
    if (exp_q.size() > 0)
    begin
      want = exp_q.pop_front();
      assert (rx_bits == 16)
      else
      begin
        $display("ERR sck_o rising edges exp %h got %h", 16, rx_bits);
        err_val++;
      end
      check_level("dc_o", dc_o, ~want.is_cmd);
      assert (rx_word == want.word)
      else
      begin
        $display("ERR sdo_o word exp %h got %h", want.word, rx_word);
        err_val++;
      end
    end
  endtask

  // grant after 0 to 7 cycles, held until the request drops
  initial
  begin : grant_model
    int unsigned delay;
    spi_ack_i = 1'b0;
    forever
    begin
      @(negedge clk);
      if (spi_req_o && !grant_hold)
      begin
        delay = next_rand() % 8;
        repeat (delay)
          @(negedge clk);
        spi_ack_i = 1'b1;
        while (spi_req_o)
          @(negedge clk);
        spi_ack_i = 1'b0;
      end
    end
  end

  // serial receiver and link monitor
  always @(negedge clk)
  begin
    if (arst_n_i)
    begin
      if (spi_done_o)
        done_cnt++;
      if (spi_req_o && !spi_ack_i)
      begin
        assert (cs_o)
        else
        begin
          $display("chip select went low before the bus grant");
          err_other++;
        end
      end
      if (!cs_o && cs_prev)
        rx_bits = 0;
      if (!cs_o && sck_o && !sck_prev)
      begin
        rx_word = {rx_word[14:0], sdo_o};
        rx_bits++;
      end
      if (cs_o && !cs_prev)
        check_frame();
    end
    sck_prev = sck_o;
    cs_prev  = cs_o;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > MAX_CYCLES)
    begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin : stimulus
    wb_dat_t rdat;
    bus_i    = '0;
    arst_n_i = 1'b0;
    foreach (STIM[i])
    begin
      if (is_frame(STIM[i]))
        exp_q.push_back(lcd_entry_t'{STIM[i].idx == CM, STIM[i].dat[15:0]});
    end
    frames_total = exp_q.size();
    repeat (16)
      @(negedge clk);
    arst_n_i = 1'b1;
    @(negedge clk);
    check_level("bus_o.ack", bus_o.ack, 1'b0);
    check_level("spi_req_o", spi_req_o, 1'b0);
    check_level("spi_done_o", spi_done_o, 1'b0);
    check_level("cs_o", cs_o, 1'b1);
    check_level("sck_o", sck_o, 1'b0);
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      if (STIM[i].settle)
        wait_idle();
      if (STIM[i].hold)
        grant_hold = 1'b1;
      wb_access(STIM[i], rdat);
      if (is_frame(STIM[i]))
        frames_sent++;
      assert (rdat == STIM[i].exp)
      else
      begin
        $display("ERR bus_o.dat row %0d exp %h got %h", i, STIM[i].exp, rdat);
        err_val++;
      end
    end
    wait_idle();
    assert (done_cnt == frames_total)
    else
    begin
      $display("ERR spi_done_o pulses exp %h got %h", frames_total, done_cnt);
      err_val++;
    end
    assert (stall_seen)
    else
    begin
      $display("the write burst was never held off by a full FIFO");
      err_other++;
    end
    $display("errors: %0d value, %0d protocol, frames %0d of %0d", err_val, err_other,
             frames_rx, frames_total);
    if (err_val + err_other == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
